// ==== all.f ====
cpu_mem_pkg.sv
mem_port_if.sv
reset_stretch.sv
fetch_port.sv
load_store_unit.sv
bus_arbiter.sv
mem_subsys_top.sv
tb_clock.sv
tb_sva.sv
tb_top.sv

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import cpu_mem_pkg::*; (
    input  logic              Clk,
    input  logic              i_rst,
    mem_port_if.arbiter       inst_port,
    mem_port_if.arbiter       data_port,
    output logic              o_bus_valid,
    input  logic              i_bus_ready,
    output word_t             o_bus_addr,
    output logic              o_bus_write,
    output word_t             o_bus_wdata,
    output logic [STRB_W-1:0] o_bus_wstrb,
    output mem_size_e         o_bus_size,
    input  logic              i_bus_rvalid,
    input  word_t             i_bus_rdata
);

    arb_state_e state;
    logic       sel_data;
    logic       sel_inst;

    // In idle the choice is combinational so a request reaches the bus at once
    assign sel_data = (state == ARB_DATA) || (state == ARB_IDLE && data_port.valid);
    assign sel_inst = (state == ARB_INST) ||
                      (state == ARB_IDLE && !data_port.valid && inst_port.valid);

    always_comb begin
        if (sel_data) begin
            o_bus_valid = data_port.valid;
            o_bus_addr  = data_port.addr;
            o_bus_write = data_port.write;
            o_bus_wdata = data_port.wdata;
            o_bus_wstrb = data_port.wstrb;
            o_bus_size  = data_port.size;
        end else begin
            o_bus_valid = sel_inst && inst_port.valid;
            o_bus_addr  = inst_port.addr;
            o_bus_write = inst_port.write;
            o_bus_wdata = inst_port.wdata;
            o_bus_wstrb = inst_port.wstrb;
            o_bus_size  = inst_port.size;
        end
    end

    assign data_port.ready  = sel_data && i_bus_ready;
    assign inst_port.ready  = sel_inst && i_bus_ready;
    assign data_port.rvalid = (state == ARB_DATA) && i_bus_rvalid;
    assign inst_port.rvalid = (state == ARB_INST) && i_bus_rvalid;
    assign data_port.rdata  = i_bus_rdata;
    assign inst_port.rdata  = i_bus_rdata;

    // The owner keeps the bus through any stall until its response returns
    always_ff @(posedge Clk) begin
        if (i_rst) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (data_port.valid) begin
                        state <= ARB_DATA;
                    end else if (inst_port.valid) begin
                        state <= ARB_INST;
                    end
                end
                ARB_INST, ARB_DATA: begin
                    if (i_bus_rvalid) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

// ==== cpu_mem_pkg.sv ====
package cpu_mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // Core reset stays asserted this many cycles after the external reset ends
    localparam int RESET_HOLD_CYCLES = 16;
    localparam int RESET_CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

    typedef logic [DATA_W-1:0] word_t;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_e;

    // Same encoding as the size field of the external bus
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_WAIT // Waiting for the grant, the handshake or the response
    } port_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INST,
        ARB_DATA
    } arb_state_e;

endpackage

// ==== fetch_port.sv ====
`timescale 1ns/1ps

module fetch_port import cpu_mem_pkg::*; (
    input  logic  Clk,
    input  logic  i_rst,
    input  logic  i_fetch_req,
    input  word_t i_fetch_pc,
    output word_t o_fetch_instr,
    output logic  o_fetch_done,
    mem_port_if.requester bus
);

    port_state_e state;
    logic        valid_q;
    word_t       pc_q;

    // Fetch is always a plain word read
    assign bus.valid = valid_q;
    assign bus.addr  = pc_q;
    assign bus.write = 1'b0;
    assign bus.wdata = '0;
    assign bus.wstrb = '1;
    assign bus.size  = SIZE_WORD;

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            state        <= PORT_IDLE;
            valid_q      <= 1'b0;
            o_fetch_done <= 1'b0;
        end else begin
            o_fetch_done <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (i_fetch_req) begin
                        state   <= PORT_WAIT;
                        valid_q <= 1'b1;
                    end
                end
                PORT_WAIT: begin
                    if (valid_q && bus.ready) begin
                        valid_q <= 1'b0;
                    end
                    if (bus.rvalid) begin
                        state        <= PORT_IDLE;
                        o_fetch_done <= 1'b1;
                    end
                end
                default: state <= PORT_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == PORT_IDLE && i_fetch_req) begin
            pc_q <= i_fetch_pc;
        end
        if (state == PORT_WAIT && bus.rvalid) begin
            o_fetch_instr <= bus.rdata;
        end
    end

endmodule

// ==== load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit import cpu_mem_pkg::*; (
    input  logic    Clk,
    input  logic    i_rst,
    input  logic    i_mem_req,
    input  mem_op_e i_mem_op,
    input  word_t   i_mem_addr,
    input  word_t   i_mem_wdata,
    output word_t   o_mem_rdata,
    output logic    o_mem_done,
    output logic    o_mem_error,
    mem_port_if.requester bus
);

    port_state_e       state;
    logic              valid_q;
    logic              err_pend; // Misaligned request, answered without the bus
    mem_op_e           op_q;
    word_t             addr_q;
    word_t             wdata_q;
    logic [STRB_W-1:0] strb_q;
    mem_size_e         size_q;
    logic              write_q;

    mem_size_e         req_size;
    logic              req_store;
    logic              req_misaligned;
    logic [STRB_W-1:0] req_strb;
    word_t             req_wdata;
    word_t             lane_data;
    word_t             load_data;

    always_comb begin
        case (i_mem_op)
            LB, LBU, SB: req_size = SIZE_BYTE;
            LH, LHU, SH: req_size = SIZE_HALF;
            default:     req_size = SIZE_WORD;
        endcase
    end

    assign req_store = (i_mem_op == SB) || (i_mem_op == SH) || (i_mem_op == SW);
    assign req_misaligned = ((req_size == SIZE_HALF) && i_mem_addr[0]) ||
                            ((req_size == SIZE_WORD) && (i_mem_addr[1:0] != 2'b00));

    // Little-endian lanes, narrow store data is copied into every lane
    always_comb begin
        case (req_size)
            SIZE_BYTE: begin
                req_strb  = STRB_W'(1) << i_mem_addr[1:0];
                req_wdata = {4{i_mem_wdata[7:0]}};
            end
            SIZE_HALF: begin
                req_strb  = STRB_W'(4'b0011) << {i_mem_addr[1], 1'b0};
                req_wdata = {2{i_mem_wdata[15:0]}};
            end
            default: begin
                req_strb  = '1;
                req_wdata = i_mem_wdata;
            end
        endcase
    end

    assign lane_data = bus.rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (op_q)
            LB:      load_data = {{24{lane_data[7]}}, lane_data[7:0]};
            LBU:     load_data = {24'd0, lane_data[7:0]};
            LH:      load_data = {{16{lane_data[15]}}, lane_data[15:0]};
            LHU:     load_data = {16'd0, lane_data[15:0]};
            LW:      load_data = bus.rdata;
            default: load_data = '0; // Stores return zero
        endcase
    end

    assign bus.valid = valid_q;
    assign bus.addr  = addr_q;
    assign bus.write = write_q;
    assign bus.wdata = wdata_q;
    assign bus.wstrb = strb_q;
    assign bus.size  = size_q;

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            state       <= PORT_IDLE;
            valid_q     <= 1'b0;
            err_pend    <= 1'b0;
            o_mem_done  <= 1'b0;
            o_mem_error <= 1'b0;
        end else begin
            o_mem_done  <= 1'b0;
            o_mem_error <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (i_mem_req) begin
                        state    <= PORT_WAIT;
                        valid_q  <= !req_misaligned;
                        err_pend <= req_misaligned;
                    end
                end
                PORT_WAIT: begin
                    if (err_pend) begin
                        state       <= PORT_IDLE;
                        err_pend    <= 1'b0;
                        o_mem_done  <= 1'b1;
                        o_mem_error <= 1'b1;
                    end else begin
                        if (valid_q && bus.ready) begin
                            valid_q <= 1'b0;
                        end
                        if (bus.rvalid) begin
                            state      <= PORT_IDLE;
                            o_mem_done <= 1'b1;
                        end
                    end
                end
                default: state <= PORT_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == PORT_IDLE && i_mem_req) begin
            op_q    <= i_mem_op;
            addr_q  <= i_mem_addr;
            wdata_q <= req_wdata;
            strb_q  <= req_strb;
            size_q  <= req_size;
            write_q <= req_store;
        end
        if (state == PORT_WAIT && err_pend) begin
            o_mem_rdata <= '0;
        end else if (state == PORT_WAIT && bus.rvalid) begin
            o_mem_rdata <= load_data;
        end
    end

endmodule

// ==== mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if import cpu_mem_pkg::*; ();

    logic              valid;
    logic              ready;
    logic [ADDR_W-1:0] addr;
    logic              write;
    word_t             wdata;
    logic [STRB_W-1:0] wstrb;
    mem_size_e         size;
    logic              rvalid; // One-cycle strobe, also the write acknowledge
    word_t             rdata;

    modport requester (
        output valid, addr, write, wdata, wstrb, size,
        input  ready, rvalid, rdata
    );

    modport arbiter (
        input  valid, addr, write, wdata, wstrb, size,
        output ready, rvalid, rdata
    );

endinterface

// ==== mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top import cpu_mem_pkg::*; (
    input  logic              Clk,
    input  logic              Myreset,
    input  logic              i_fetch_req,
    input  word_t             i_fetch_pc,
    output word_t             o_fetch_instr,
    output logic              o_fetch_done,
    input  logic              i_mem_req,
    input  mem_op_e           i_mem_op,
    input  word_t             i_mem_addr,
    input  word_t             i_mem_wdata,
    output word_t             o_mem_rdata,
    output logic              o_mem_done,
    output logic              o_mem_error,
    output logic              o_core_rst,
    output logic              o_bus_valid,
    input  logic              i_bus_ready,
    output word_t             o_bus_addr,
    output logic              o_bus_write,
    output word_t             o_bus_wdata,
    output logic [STRB_W-1:0] o_bus_wstrb,
    output mem_size_e         o_bus_size,
    input  logic              i_bus_rvalid,
    input  word_t             i_bus_rdata
);

    mem_port_if if_inst ();
    mem_port_if if_data ();

    reset_stretch u_reset_stretch (
        .Clk        (Clk),
        .Myreset    (Myreset),
        .o_core_rst (o_core_rst)
    );

    fetch_port u_fetch_port (
        .Clk           (Clk),
        .i_rst         (o_core_rst),
        .i_fetch_req   (i_fetch_req),
        .i_fetch_pc    (i_fetch_pc),
        .o_fetch_instr (o_fetch_instr),
        .o_fetch_done  (o_fetch_done),
        .bus           (if_inst)
    );

    load_store_unit u_load_store_unit (
        .Clk         (Clk),
        .i_rst       (o_core_rst),
        .i_mem_req   (i_mem_req),
        .i_mem_op    (i_mem_op),
        .i_mem_addr  (i_mem_addr),
        .i_mem_wdata (i_mem_wdata),
        .o_mem_rdata (o_mem_rdata),
        .o_mem_done  (o_mem_done),
        .o_mem_error (o_mem_error),
        .bus         (if_data)
    );

    bus_arbiter u_bus_arbiter (
        .Clk          (Clk),
        .i_rst        (o_core_rst),
        .inst_port    (if_inst),
        .data_port    (if_data),
        .o_bus_valid  (o_bus_valid),
        .i_bus_ready  (i_bus_ready),
        .o_bus_addr   (o_bus_addr),
        .o_bus_write  (o_bus_write),
        .o_bus_wdata  (o_bus_wdata),
        .o_bus_wstrb  (o_bus_wstrb),
        .o_bus_size   (o_bus_size),
        .i_bus_rvalid (i_bus_rvalid),
        .i_bus_rdata  (i_bus_rdata)
    );

endmodule

// ==== reset_stretch.sv ====
`timescale 1ns/1ps

module reset_stretch import cpu_mem_pkg::*; (
    input  logic Clk,
    input  logic Myreset,
    output logic o_core_rst
);

    logic [RESET_CNT_W-1:0] hold_cnt;

    // The counter runs only while the core reset is still held
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            hold_cnt   <= '0;
            o_core_rst <= 1'b1;
        end else if (o_core_rst) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == RESET_CNT_W'(RESET_HOLD_CYCLES - 1)) begin
                o_core_rst <= 1'b0; // Low from the cycle after the last held one
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
verilator --binary --timing --assert --top-module tb_top -f all.f -o tb_top_sim
./obj_dir/tb_top_sim

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #10 o_clk = ~o_clk; // 20 ns period

endmodule

// ==== tb_sva.sv ====
`timescale 1ns/1ps

module bus_arbiter_sva import cpu_mem_pkg::*; (
    input logic              Clk,
    input logic              i_rst,
    input logic              i_bus_valid,
    input logic              i_bus_ready,
    input word_t             i_bus_addr,
    input logic              i_bus_write,
    input word_t             i_bus_wdata,
    input logic [STRB_W-1:0] i_bus_wstrb,
    input mem_size_e         i_bus_size,
    input logic              i_bus_rvalid,
    input logic              i_inst_rvalid,
    input logic              i_data_rvalid
);

    // A stalled request keeps valid and all of its fields until ready
    a_req_stable: assert property (@(posedge Clk) disable iff (i_rst)
        i_bus_valid && !i_bus_ready |=> i_bus_valid && $stable(i_bus_addr) &&
        $stable(i_bus_write) && $stable(i_bus_wdata) && $stable(i_bus_wstrb) &&
        $stable(i_bus_size))
        else $error("Bus request changed while it was stalled");

    // Every response goes to the one port that owns the bus
    a_one_rvalid: assert property (@(posedge Clk)
        i_bus_rvalid |-> $onehot({i_inst_rvalid, i_data_rvalid}))
        else $error("Response strobe did not reach exactly one port");

    a_idle_in_reset: assert property (@(posedge Clk) i_rst && $past(i_rst) |-> !i_bus_valid)
        else $error("Bus valid was high during the core reset");

endmodule

bind bus_arbiter bus_arbiter_sva u_bus_arbiter_sva (
    .Clk           (Clk),
    .i_rst         (i_rst),
    .i_bus_valid   (o_bus_valid),
    .i_bus_ready   (i_bus_ready),
    .i_bus_addr    (o_bus_addr),
    .i_bus_write   (o_bus_write),
    .i_bus_wdata   (o_bus_wdata),
    .i_bus_wstrb   (o_bus_wstrb),
    .i_bus_size    (o_bus_size),
    .i_bus_rvalid  (i_bus_rvalid),
    .i_inst_rvalid (inst_port.rvalid),
    .i_data_rvalid (data_port.rvalid)
);

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top import cpu_mem_pkg::*; ();

    typedef enum logic [1:0] {
        KIND_FETCH,
        KIND_DATA,
        KIND_BOTH
    } row_kind_e;

    typedef struct packed {
        row_kind_e kind;
        mem_op_e   op;
        word_t     addr;
        word_t     wdata;
        word_t     pc;
        word_t     exp_rdata;
        word_t     exp_instr;
        logic      exp_err;
    } row_t;

    logic              Clk;
    logic              Myreset;
    logic              i_fetch_req;
    word_t             i_fetch_pc;
    word_t             o_fetch_instr;
    logic              o_fetch_done;
    logic              i_mem_req;
    mem_op_e           i_mem_op;
    word_t             i_mem_addr;
    word_t             i_mem_wdata;
    word_t             o_mem_rdata;
    logic              o_mem_done;
    logic              o_mem_error;
    logic              o_core_rst;
    logic              o_bus_valid;
    logic              i_bus_ready = 1'b0;
    word_t             o_bus_addr;
    logic              o_bus_write;
    word_t             o_bus_wdata;
    logic [STRB_W-1:0] o_bus_wstrb;
    mem_size_e         o_bus_size;
    logic              i_bus_rvalid = 1'b0;
    word_t             i_bus_rdata = '0;

    row_t        rows [$];
    word_t       req_log [$]; // Address of every bus handshake in order
    mem_size_e   size_log [$];
    word_t       mem [0:255];
    logic [31:0] rng_state;
    logic        resp_pend;
    logic [1:0]  resp_wait;
    word_t       resp_data;

    tb_clock u_tb_clock (
        .o_clk (Clk)
    );

    mem_subsys_top u_mem_subsys_top (
        .Clk (Clk), .Myreset (Myreset),
        .i_fetch_req (i_fetch_req), .i_fetch_pc (i_fetch_pc),
        .o_fetch_instr (o_fetch_instr), .o_fetch_done (o_fetch_done),
        .i_mem_req (i_mem_req), .i_mem_op (i_mem_op), .i_mem_addr (i_mem_addr),
        .i_mem_wdata (i_mem_wdata), .o_mem_rdata (o_mem_rdata),
        .o_mem_done (o_mem_done), .o_mem_error (o_mem_error), .o_core_rst (o_core_rst),
        .o_bus_valid (o_bus_valid), .i_bus_ready (i_bus_ready), .o_bus_addr (o_bus_addr),
        .o_bus_write (o_bus_write), .o_bus_wdata (o_bus_wdata), .o_bus_wstrb (o_bus_wstrb),
        .o_bus_size (o_bus_size), .i_bus_rvalid (i_bus_rvalid), .i_bus_rdata (i_bus_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Power-up contents of the memory model
    function automatic word_t fill_word(input logic [31:0] a);
        return {a[15:0] ^ a[31:16], ~a[15:0] ^ a[31:16]};
    endfunction

    // Bus size code that a data access of this opcode must carry
    function automatic mem_size_e expected_size(input mem_op_e op);
        case (op)
            LB, LBU, SB: return SIZE_BYTE;
            LH, LHU, SH: return SIZE_HALF;
            default:     return SIZE_WORD;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got == exp) else begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic add_row(input row_kind_e kind, input mem_op_e op, input word_t addr,
                           input word_t wdata, input word_t pc, input word_t exp_rdata,
                           input word_t exp_instr, input logic exp_err);
        row_t r;
        r = {kind, op, addr, wdata, pc, exp_rdata, exp_instr, exp_err};
        rows.push_back(r);
    endtask

    // Instruction words come from fill_word and data comes from the stores above it
    task automatic load_table();
        add_row(KIND_FETCH, LW, 32'h00, 32'h0, 32'h200, 32'h0, 32'h0200fdff, 1'b0);
        add_row(KIND_FETCH, LW, 32'h00, 32'h0, 32'h204, 32'h0, 32'h0204fdfb, 1'b0);
        add_row(KIND_DATA, SW, 32'h40, 32'h11223344, 32'h0, 32'h0, 32'h0, 1'b0);
        add_row(KIND_DATA, SB, 32'h41, 32'h000000ab, 32'h0, 32'h0, 32'h0, 1'b0);
        add_row(KIND_DATA, SB, 32'h43, 32'h123456f0, 32'h0, 32'h0, 32'h0, 1'b0);
        add_row(KIND_DATA, SH, 32'h46, 32'h00008001, 32'h0, 32'h0, 32'h0, 1'b0);
        add_row(KIND_DATA, SW, 32'h48, 32'hcafe7f80, 32'h0, 32'h0, 32'h0, 1'b0);
        add_row(KIND_DATA, LW, 32'h40, 32'h0, 32'h0, 32'hf022ab44, 32'h0, 1'b0);
        add_row(KIND_DATA, LB, 32'h41, 32'h0, 32'h0, 32'hffffffab, 32'h0, 1'b0);
        add_row(KIND_DATA, LBU, 32'h41, 32'h0, 32'h0, 32'h000000ab, 32'h0, 1'b0);
        add_row(KIND_DATA, LB, 32'h40, 32'h0, 32'h0, 32'h00000044, 32'h0, 1'b0);
        add_row(KIND_DATA, LB, 32'h43, 32'h0, 32'h0, 32'hfffffff0, 32'h0, 1'b0);
        add_row(KIND_DATA, LH, 32'h46, 32'h0, 32'h0, 32'hffff8001, 32'h0, 1'b0);
        add_row(KIND_DATA, LHU, 32'h46, 32'h0, 32'h0, 32'h00008001, 32'h0, 1'b0);
        add_row(KIND_DATA, LH, 32'h44, 32'h0, 32'h0, 32'hffffffbb, 32'h0, 1'b0);
        add_row(KIND_DATA, LHU, 32'h48, 32'h0, 32'h0, 32'h00007f80, 32'h0, 1'b0);
        add_row(KIND_DATA, LH, 32'h4a, 32'h0, 32'h0, 32'hffffcafe, 32'h0, 1'b0);
        add_row(KIND_DATA, LBU, 32'h4b, 32'h0, 32'h0, 32'h000000ca, 32'h0, 1'b0);
        add_row(KIND_DATA, LB, 32'h48, 32'h0, 32'h0, 32'hffffff80, 32'h0, 1'b0);
        add_row(KIND_DATA, LH, 32'h41, 32'h0, 32'h0, 32'h0, 32'h0, 1'b1);
        add_row(KIND_DATA, LW, 32'h42, 32'h0, 32'h0, 32'h0, 32'h0, 1'b1);
        add_row(KIND_DATA, SH, 32'h43, 32'h0000dead, 32'h0, 32'h0, 32'h0, 1'b1);
        add_row(KIND_DATA, SW, 32'h41, 32'hffffffff, 32'h0, 32'h0, 32'h0, 1'b1);
        add_row(KIND_DATA, LW, 32'h40, 32'h0, 32'h0, 32'hf022ab44, 32'h0, 1'b0);
        add_row(KIND_BOTH, SW, 32'h4c, 32'h01234567, 32'h208, 32'h0, 32'h0208fdf7, 1'b0);
        add_row(KIND_BOTH, LW, 32'h4c, 32'h0, 32'h20c, 32'h01234567, 32'h020cfdf3, 1'b0);
        add_row(KIND_BOTH, LBU, 32'h4e, 32'h0, 32'h210, 32'h00000023, 32'h0210fdef, 1'b0);
    endtask

    // Memory model with random ready stalls and response delays
    always @(posedge Clk) begin
        if (Myreset) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] = fill_word(32'(i * 4));
            end
            rng_state    <= 32'h3df;
            i_bus_ready  <= 1'b0;
            i_bus_rvalid <= 1'b0;
            resp_pend    <= 1'b0;
            resp_wait    <= 2'd0;
        end else begin
            rng_state    <= xorshift32(rng_state);
            i_bus_rvalid <= 1'b0;
            assert (!(resp_pend && o_bus_valid)) else begin
                report_failure("A second bus request appeared while a response was pending");
            end
            if (resp_pend) begin
                if (resp_wait == 2'd0) begin
                    i_bus_rvalid <= 1'b1;
                    i_bus_rdata  <= resp_data;
                    resp_pend    <= 1'b0;
                end else begin
                    resp_wait <= resp_wait - 2'd1;
                end
            end else if (o_bus_valid && i_bus_ready) begin
                req_log.push_back(o_bus_addr);
                size_log.push_back(o_bus_size);
                resp_data = '0; // Writes are acknowledged with zero data
                if (o_bus_write) begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (o_bus_wstrb[b]) begin
                            mem[o_bus_addr[9:2]][8*b +: 8] = o_bus_wdata[8*b +: 8];
                        end
                    end
                end else begin
                    resp_data = mem[o_bus_addr[9:2]];
                end
                i_bus_ready <= 1'b0;
                resp_pend   <= 1'b1;
                resp_wait   <= rng_state[3:2];
            end else begin
                i_bus_ready <= (rng_state[1:0] != 2'b00);
            end
        end
    end

    task automatic check_reset_hold();
        int  held;
        int  cycles;
        logic released;
        held     = 0;
        cycles   = 0;
        released = 1'b0;
        while (!released) begin
            @(posedge Clk);
            cycles++;
            if (cycles > 100) begin
                report_failure("Timeout while waiting for the core reset to end");
            end
            assert (!o_bus_valid) else begin
                report_failure("o_bus_valid went high while the core was held in reset");
            end
            if (o_core_rst) begin
                held++;
            end else begin
                released = 1'b1;
            end
            i_fetch_req <= (held < RESET_HOLD_CYCLES - 4); // Strobes land inside the hold
            i_fetch_pc  <= 32'h200;
        end
        check_word("o_core_rst hold cycles", 32'(held), 32'(RESET_HOLD_CYCLES));
        for (int k = 0; k < 4; k++) begin
            @(posedge Clk);
            assert (!o_bus_valid && !o_fetch_done) else begin
                report_failure("A fetch strobe given during reset reached the bus");
            end
        end
    endtask

    task automatic run_row(input row_t r);
        logic want_fetch;
        logic want_mem;
        logic got_fetch;
        logic got_mem;
        int   cycles;
        int   base;
        int   fetch_idx;
        want_fetch = (r.kind != KIND_DATA);
        want_mem   = (r.kind != KIND_FETCH);
        got_fetch  = 1'b0;
        got_mem    = 1'b0;
        cycles     = 0;
        @(posedge Clk);
        base = req_log.size();
        if (want_fetch) begin
            i_fetch_req <= 1'b1;
            i_fetch_pc  <= r.pc;
        end
        if (want_mem) begin
            i_mem_req   <= 1'b1;
            i_mem_op    <= r.op;
            i_mem_addr  <= r.addr;
            i_mem_wdata <= r.wdata;
        end
        while ((want_fetch && !got_fetch) || (want_mem && !got_mem)) begin
            @(posedge Clk);
            cycles++;
            i_fetch_req <= 1'b0;
            i_mem_req   <= 1'b0;
            if (cycles > 200) begin
                report_failure("Timeout while waiting for a done pulse");
            end
            if (r.exp_err) begin
                assert (!o_bus_valid) else begin
                    report_failure("A misaligned access raised o_bus_valid");
                end
            end
            assert (!o_mem_error || o_mem_done) else begin
                report_failure("o_mem_error pulsed without o_mem_done");
            end
            if (o_fetch_done) begin
                assert (want_fetch && !got_fetch) else begin
                    report_failure("o_fetch_done pulsed with no fetch pending");
                end
                check_word("o_fetch_instr", o_fetch_instr, r.exp_instr);
                got_fetch = 1'b1;
            end
            if (o_mem_done) begin
                assert (want_mem && !got_mem) else begin
                    report_failure("o_mem_done pulsed with no data access pending");
                end
                check_word("o_mem_rdata", o_mem_rdata, r.exp_rdata);
                check_word("o_mem_error", {31'd0, o_mem_error}, {31'd0, r.exp_err});
                if (r.exp_err) begin
                    check_word("misaligned done latency", 32'(cycles), 32'd3);
                end
                got_mem = 1'b1;
            end
        end
        if (r.exp_err) begin
            check_word("bus requests for a misaligned access", 32'(req_log.size() - base), 0);
        end
        if (r.kind == KIND_BOTH) begin
            check_word("bus requests", 32'(req_log.size() - base), 32'd2);
            check_word("first o_bus_addr", req_log[base], r.addr);
        end
        if (want_mem && !r.exp_err) begin
            check_word("o_bus_size", 32'(size_log[base]), 32'(expected_size(r.op)));
        end
        if (want_fetch) begin
            fetch_idx = want_mem ? base + 1 : base;
            check_word("o_bus_size", 32'(size_log[fetch_idx]), 32'(SIZE_WORD));
        end
    endtask

    initial begin
        Myreset     = 1'b1;
        i_fetch_req = 1'b0;
        i_fetch_pc  = '0;
        i_mem_req   = 1'b0;
        i_mem_op    = LW;
        i_mem_addr  = '0;
        i_mem_wdata = '0;
        load_table();
        repeat (4) @(posedge Clk);
        Myreset <= 1'b0;
        check_reset_hold();
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule
